/* hw/mac_multiply.sv */
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_multiply
(
        input  logic               i_clk,
        input  logic               i_reset,

        input  logic               i_start,
        input  logic               i_abort,
        input  logic               i_accumulate,

        input  mac_pkg::mac_word_t i_rm,
        input  mac_pkg::mac_word_t i_rs,
        input  mac_pkg::mac_word_t i_rn,        // Addend.

        output mac_pkg::mac_word_t o_result,
        output logic               o_done
);
        import mac_pkg::*;

        localparam int HALF_W = `MAC_WORD_W / 2;

        mac_mul_state_t    state_ff;
        logic              done_ff;

        mac_word_t         rm_ff;
        mac_word_t         rs_ff;
        mac_word_t         rn_ff;
        logic              acc_ff;

        // Partial products.
        mac_word_t         prod_ll_ff;
        logic [HALF_W-1:0] prod_lh_ff;  // Only the low half survives the shift.
        logic [HALF_W-1:0] prod_hl_ff;
        mac_word_t         result_ff;

        logic [HALF_W-1:0] op_a;
        logic [HALF_W-1:0] op_b;
        mac_word_t         product;
        mac_word_t         addend;
        mac_word_t         sum;

        //##############################################################
        // One shared 16x16 multiplier, operands picked by step.
        //##############################################################

        always_comb
        begin
                case (state_ff)
                        STEP_LH:
                        begin
                                op_a = rm_ff[HALF_W-1:0];
                                op_b = rs_ff[`MAC_WORD_W-1:HALF_W];
                        end
                        STEP_HL:
                        begin
                                op_a = rm_ff[`MAC_WORD_W-1:HALF_W];
                                op_b = rs_ff[HALF_W-1:0];
                        end
                        default:
                        begin
                                op_a = rm_ff[HALF_W-1:0];
                                op_b = rs_ff[HALF_W-1:0];
                        end
                endcase
        end

        assign product = mac_word_t'(op_a) * mac_word_t'(op_b);
        assign addend  = acc_ff ? rn_ff : '0;

        // High by high never reaches the low word, so it is skipped.
        assign sum = prod_ll_ff
                   + {prod_lh_ff, {HALF_W{1'b0}}}
                   + {prod_hl_ff, {HALF_W{1'b0}}}
                   + addend;

        //##############################################################
        // Sequence.
        //##############################################################

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_ff <= IDLE;
                        done_ff  <= 1'b0;
                end
                else
                begin
                        done_ff <= 1'b0;

                        if (i_abort)
                                state_ff <= IDLE;       // No done follows.
                        else
                        begin
                                case (state_ff)
                                        IDLE:     if (i_start) state_ff <= STEP_LL;
                                        STEP_LL:  state_ff <= STEP_LH;
                                        STEP_LH:  state_ff <= STEP_HL;
                                        STEP_HL:  state_ff <= STEP_ACC;
                                        STEP_ACC:
                                        begin
                                                state_ff <= IDLE;
                                                done_ff  <= 1'b1;
                                        end
                                        default:  state_ff <= IDLE;
                                endcase
                        end
                end
        end

        // Operands are captured on start, so writeback cannot disturb them.
        always_ff @(posedge i_clk)
        begin
                if (state_ff == IDLE && i_start)
                begin
                        rm_ff  <= i_rm;
                        rs_ff  <= i_rs;
                        rn_ff  <= i_rn;
                        acc_ff <= i_accumulate;
                end

                if (state_ff == STEP_LL)
                        prod_ll_ff <= product;
                if (state_ff == STEP_LH)
                        prod_lh_ff <= product[HALF_W-1:0];
                if (state_ff == STEP_HL)
                        prod_hl_ff <= product[HALF_W-1:0];
                if (state_ff == STEP_ACC)
                        result_ff  <= sum;
        end

        assign o_result = result_ff;
        assign o_done   = done_ff;

endmodule

/* hw/mac_pkg.sv */
`include "mac_defines.svh"

package mac_pkg;

        // One data word, unsigned.
        typedef logic [`MAC_WORD_W-1:0] mac_word_t;

        // Register number.
        typedef logic [`MAC_IDX_W-1:0] mac_idx_t;

        // Multiplier sequence.
        // One encoding per step plus the idle state.
        typedef enum logic [$clog2(`MAC_MUL_STEPS+1)-1:0]
        {
                IDLE,           // Waiting for start.
                STEP_LL,        // Low by low.
                STEP_LH,        // Low by high.
                STEP_HL,        // High by low.
                STEP_ACC        // Final sum and addend.
        } mac_mul_state_t;

endpackage

/* hw/mac_regfile.sv */
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_regfile
(
        input  logic               i_clk,
        input  logic               i_reset,

        // Host side.
        input  logic               i_host_we,
        input  mac_pkg::mac_idx_t  i_host_waddr,
        input  mac_pkg::mac_word_t i_host_wdata,
        input  mac_pkg::mac_idx_t  i_host_raddr,
        output mac_pkg::mac_word_t o_host_rdata,

        // Operand reads for the multiplier.
        input  mac_pkg::mac_idx_t  i_rm_idx,
        input  mac_pkg::mac_idx_t  i_rs_idx,
        input  mac_pkg::mac_idx_t  i_rn_idx,
        output mac_pkg::mac_word_t o_rm,
        output mac_pkg::mac_word_t o_rs,
        output mac_pkg::mac_word_t o_rn,

        // Result writeback.
        input  logic               i_wb_we,
        input  mac_pkg::mac_idx_t  i_wb_idx,
        input  mac_pkg::mac_word_t i_wb_data
);
        import mac_pkg::*;

        mac_word_t regs_ff [`MAC_NUM_REGS];

        // Writeback has priority over the host.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < `MAC_NUM_REGS; i++)
                        begin
                                regs_ff[i] <= '0;
                        end
                end
                else if (i_wb_we)
                begin
                        regs_ff[i_wb_idx] <= i_wb_data;
                end
                else if (i_host_we)
                begin
                        regs_ff[i_host_waddr] <= i_host_wdata;  // Lost on a collision.
                end
        end

        // All reads are combinational.
        assign o_host_rdata = regs_ff[i_host_raddr];
        assign o_rm         = regs_ff[i_rm_idx];
        assign o_rs         = regs_ff[i_rs_idx];
        assign o_rn         = regs_ff[i_rn_idx];

endmodule

/* hw/mac_sequencer.sv */
`timescale 1ns/1ps

module mac_sequencer
(
        input  logic               i_clk,
        input  logic               i_reset,

        // Command port.
        input  logic               i_cmd_valid,
        input  mac_pkg::mac_idx_t  i_cmd_rd,
        input  mac_pkg::mac_idx_t  i_cmd_rm,
        input  mac_pkg::mac_idx_t  i_cmd_rs,
        input  mac_pkg::mac_idx_t  i_cmd_rn,
        input  logic               i_cmd_accumulate,
        input  logic               i_flush,

        // Operand indices to the register file.
        output mac_pkg::mac_idx_t  o_rm_idx,
        output mac_pkg::mac_idx_t  o_rs_idx,
        output mac_pkg::mac_idx_t  o_rn_idx,

        // Multiplier control.
        output logic               o_mul_start,
        output logic               o_mul_acc,
        output logic               o_mul_abort,
        input  logic               i_mul_done,
        input  mac_pkg::mac_word_t i_mul_result,

        // Writeback and status.
        output logic               o_wb_we,
        output mac_pkg::mac_idx_t  o_wb_idx,
        output mac_pkg::mac_word_t o_wb_data,
        output logic               o_busy,
        output logic               o_done
);
        import mac_pkg::*;

        logic     busy_ff;
        logic     start_ff;
        logic     acc_ff;
        logic     accept;
        mac_idx_t rd_ff;
        mac_idx_t rm_ff;
        mac_idx_t rs_ff;
        mac_idx_t rn_ff;

        // Commands arriving while busy are dropped.
        assign accept = i_cmd_valid && !busy_ff;

        //##############################################################
        // Control.
        //##############################################################

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        busy_ff  <= 1'b0;
                        start_ff <= 1'b0;
                end
                else
                begin
                        start_ff <= accept;     // Single pulse, one cycle later.

                        if (accept)
                                busy_ff <= 1'b1;
                        else if (busy_ff && (i_flush || i_mul_done))
                                busy_ff <= 1'b0;
                end
        end

        // Command fields held for the whole operation.
        always_ff @(posedge i_clk)
        begin
                if (accept)
                begin
                        rd_ff  <= i_cmd_rd;
                        rm_ff  <= i_cmd_rm;
                        rs_ff  <= i_cmd_rs;
                        rn_ff  <= i_cmd_rn;
                        acc_ff <= i_cmd_accumulate;
                end
        end

        assign o_rm_idx    = rm_ff;
        assign o_rs_idx    = rs_ff;
        assign o_rn_idx    = rn_ff;

        assign o_mul_start = start_ff;
        assign o_mul_acc   = acc_ff;
        assign o_mul_abort = i_flush;   // Multiplier drops back to idle.

        // Done from the multiplier doubles as the write strobe.
        assign o_wb_we     = i_mul_done;
        assign o_wb_idx    = rd_ff;
        assign o_wb_data   = i_mul_result;
        assign o_busy      = busy_ff;
        assign o_done      = i_mul_done;

endmodule

/* hw/mac_top.sv */
`timescale 1ns/1ps

module mac_top
(
        input  logic               i_clk,
        input  logic               i_reset,

        // Host register access.
        input  logic               i_reg_we,
        input  mac_pkg::mac_idx_t  i_reg_waddr,
        input  mac_pkg::mac_word_t i_reg_wdata,
        input  mac_pkg::mac_idx_t  i_reg_raddr,
        output mac_pkg::mac_word_t o_reg_rdata,

        // Command port.
        input  logic               i_cmd_valid,
        input  mac_pkg::mac_idx_t  i_cmd_rd,
        input  mac_pkg::mac_idx_t  i_cmd_rm,
        input  mac_pkg::mac_idx_t  i_cmd_rs,
        input  mac_pkg::mac_idx_t  i_cmd_rn,
        input  logic               i_cmd_accumulate,
        input  logic               i_flush,

        output logic               o_busy,
        output logic               o_done
);
        import mac_pkg::*;

        mac_idx_t  seq_rm_idx, seq_rs_idx, seq_rn_idx;
        mac_word_t rf_rm, rf_rs, rf_rn;
        logic      seq_wb_we;
        mac_idx_t  seq_wb_idx;
        mac_word_t seq_wb_data;
        logic      seq_mul_start, seq_mul_acc, seq_mul_abort;
        logic      mul_done;
        mac_word_t mul_result;

        mac_regfile u_regfile
        (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_host_we    (i_reg_we),
                .i_host_waddr (i_reg_waddr),
                .i_host_wdata (i_reg_wdata),
                .i_host_raddr (i_reg_raddr),
                .o_host_rdata (o_reg_rdata),
                .i_rm_idx     (seq_rm_idx),
                .i_rs_idx     (seq_rs_idx),
                .i_rn_idx     (seq_rn_idx),
                .o_rm         (rf_rm),
                .o_rs         (rf_rs),
                .o_rn         (rf_rn),
                .i_wb_we      (seq_wb_we),
                .i_wb_idx     (seq_wb_idx),
                .i_wb_data    (seq_wb_data)
        );

        mac_sequencer u_sequencer
        (
                .i_clk            (i_clk),
                .i_reset          (i_reset),
                .i_cmd_valid      (i_cmd_valid),
                .i_cmd_rd         (i_cmd_rd),
                .i_cmd_rm         (i_cmd_rm),
                .i_cmd_rs         (i_cmd_rs),
                .i_cmd_rn         (i_cmd_rn),
                .i_cmd_accumulate (i_cmd_accumulate),
                .i_flush          (i_flush),
                .o_rm_idx         (seq_rm_idx),
                .o_rs_idx         (seq_rs_idx),
                .o_rn_idx         (seq_rn_idx),
                .o_mul_start      (seq_mul_start),
                .o_mul_acc        (seq_mul_acc),
                .o_mul_abort      (seq_mul_abort),
                .i_mul_done       (mul_done),
                .i_mul_result     (mul_result),
                .o_wb_we          (seq_wb_we),
                .o_wb_idx         (seq_wb_idx),
                .o_wb_data        (seq_wb_data),
                .o_busy           (o_busy),
                .o_done           (o_done)
        );

        // Operands come straight from the register file read ports.
        mac_multiply u_multiply
        (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_start      (seq_mul_start),
                .i_abort      (seq_mul_abort),
                .i_accumulate (seq_mul_acc),
                .i_rm         (rf_rm),
                .i_rs         (rf_rs),
                .i_rn         (rf_rn),
                .o_result     (mul_result),
                .o_done       (mul_done)
        );

endmodule

/* include/mac_defines.svh */
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

//######################################################################
// Data path sizing.
//######################################################################

`define MAC_WORD_W      32      // Width of a data word.

//######################################################################
// Register file sizing.
//######################################################################

`define MAC_NUM_REGS    16      // General registers.
`define MAC_IDX_W       4       // Bits to address one register.

// Multiplier steps between start and done, not counting IDLE.
`define MAC_MUL_STEPS   4

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_mac_top
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/Vtb_mac_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
        echo "PASS"
        exit 0
else
        echo "FAIL"
        exit 1
fi

/* src.f */
+incdir+include
hw/mac_pkg.sv
hw/mac_regfile.sv
hw/mac_sequencer.sv
hw/mac_multiply.sv
hw/mac_top.sv
tb/tb_mac_top.sv

/* tb/tb_mac_top.sv */
`timescale 1ns/1ps
`include "mac_defines.svh"

module tb_mac_top;
        import mac_pkg::*;

        localparam int CLK_PERIOD  = 10;
        localparam int DONE_EDGES  = 5;         // Edges from command edge to done.
        localparam int DONE_LIMIT  = 20;
        localparam int CMD_CYCLES  = 12;        // Issue, wait, writeback and read back.
        localparam int TEST_CYCLES = 4 + 70 + 36 * (2 + CMD_CYCLES)
                                   + 20 * (3 + CMD_CYCLES) + 40 + 60;
        localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

        logic      i_clk;
        logic      i_reset;
        logic      i_reg_we;
        mac_idx_t  i_reg_waddr;
        mac_word_t i_reg_wdata;
        mac_idx_t  i_reg_raddr;
        mac_word_t o_reg_rdata;
        logic      i_cmd_valid;
        mac_idx_t  i_cmd_rd;
        mac_idx_t  i_cmd_rm;
        mac_idx_t  i_cmd_rs;
        mac_idx_t  i_cmd_rn;
        logic      i_cmd_accumulate;
        logic      i_flush;
        logic      o_busy;
        logic      o_done;

        mac_word_t model_regs [`MAC_NUM_REGS];  // Expected register contents.
        mac_word_t lcg_state = 32'd94962;
        int        pass_count = 0;
        int        fail_count = 0;

        mac_top dut (.*);

        always #(CLK_PERIOD / 2) i_clk = ~i_clk;

        //####################################################################
        // Helpers.
        //####################################################################

        function automatic mac_word_t next_random();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // Low word of rm * rs plus the addend when accumulating.
        function automatic mac_word_t expected_result(input mac_word_t a, input mac_word_t b,
                                                      input mac_word_t n, input logic acc);
                logic [63:0] full;
                full = {32'd0, a} * {32'd0, b};
                if (acc)
                        full = full + {32'd0, n};
                return full[31:0];
        endfunction

        task automatic compare_word(input string what, input mac_word_t got,
                                    input mac_word_t exp);
                if (got !== exp)
                begin
                        $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
                        fail_count++;
                end
                else
                        pass_count++;
        endtask

        task automatic compare_bit(input string what, input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
                        fail_count++;
                end
                else
                        pass_count++;
        endtask

        task automatic compare_count(input string what, input int got, input int exp);
                if (got != exp)
                begin
                        $display("error at %0t ns: %s, got %0d expected %0d",
                                 $time, what, got, exp);
                        fail_count++;
                end
                else
                        pass_count++;
        endtask

        // Four cycles of reset. The model clears with the registers.
        task automatic hold_reset();
                i_reset = 1'b1;
                repeat (4) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;
                for (int i = 0; i < `MAC_NUM_REGS; i++)
                        model_regs[i] = '0;
        endtask

        // All tasks start and end just after a falling edge.
        task automatic write_reg(input mac_idx_t idx, input mac_word_t data);
                i_reg_we    = 1'b1;
                i_reg_waddr = idx;
                i_reg_wdata = data;
                @(posedge i_clk);
                @(negedge i_clk);
                i_reg_we = 1'b0;
                model_regs[idx] = data;
        endtask

        task automatic read_reg(input mac_idx_t idx, output mac_word_t data);
                i_reg_raddr = idx;
                #2 data = o_reg_rdata;
                @(negedge i_clk);
        endtask

        task automatic check_all_regs();
                mac_word_t got;
                for (int i = 0; i < `MAC_NUM_REGS; i++)
                begin
                        read_reg(mac_idx_t'(i), got);
                        compare_word($sformatf("register %0d", i), got, model_regs[i]);
                end
        endtask

        task automatic drive_command(input mac_idx_t rd, input mac_idx_t rm, input mac_idx_t rs,
                                     input mac_idx_t rn, input logic acc);
                i_cmd_valid      = 1'b1;
                i_cmd_rd         = rd;
                i_cmd_rm         = rm;
                i_cmd_rs         = rs;
                i_cmd_rn         = rn;
                i_cmd_accumulate = acc;
        endtask

        task automatic issue_command(input mac_idx_t rd, input mac_idx_t rm, input mac_idx_t rs,
                                     input mac_idx_t rn, input logic acc);
                drive_command(rd, rm, rs, rn, acc);
                @(posedge i_clk);                       // Command edge.
                @(negedge i_clk);
                i_cmd_valid = 1'b0;
        endtask

        task automatic wait_done(output int edges, output logic seen);
                edges = 0;
                seen  = 1'b0;
                while (!seen && edges < DONE_LIMIT)
                begin
                        @(posedge i_clk);
                        edges++;
                        @(negedge i_clk);
                        seen = o_done;
                end
                if (!seen)
                begin
                        $display("o_done never arrived within %0d cycles of a command",
                                 DONE_LIMIT);
                        fail_count++;
                end
        endtask

        task automatic run_and_check(input mac_idx_t rd, input mac_idx_t rm, input mac_idx_t rs,
                                     input mac_idx_t rn, input logic acc);
                mac_word_t expected;
                mac_word_t got;
                int        edges;
                logic      seen;
                expected = expected_result(model_regs[rm], model_regs[rs], model_regs[rn], acc);
                issue_command(rd, rm, rs, rn, acc);
                wait_done(edges, seen);
                if (seen)
                begin
                        @(posedge i_clk);               // Writeback edge.
                        @(negedge i_clk);
                        compare_bit("busy after writeback", o_busy, 1'b0);
                        compare_bit("done lasts one cycle", o_done, 1'b0);
                        model_regs[rd] = expected;
                end
                read_reg(rd, got);
                compare_word("destination register", got, model_regs[rd]);
        endtask

        //####################################################################
        // Tests.
        //####################################################################

        task automatic test_reset_and_regs();
                int errors_before;
                errors_before = fail_count;
                compare_bit("busy after reset", o_busy, 1'b0);
                compare_bit("done after reset", o_done, 1'b0);
                check_all_regs();
                for (int i = 0; i < `MAC_NUM_REGS; i++)
                        write_reg(mac_idx_t'(i), next_random());
                check_all_regs();
                issue_command(4'd1, 4'd2, 4'd3, 4'd4, 1'b1);
                hold_reset();                           // Cuts the command short.
                compare_bit("busy after reset in flight", o_busy, 1'b0);
                compare_bit("done after reset in flight", o_done, 1'b0);
                check_all_regs();
                $display("test reset_and_regs finished, %0d errors", fail_count - errors_before);
        endtask

        task automatic test_plain_multiply();
                mac_word_t corners [6];
                int        errors_before;
                errors_before = fail_count;
                corners = '{32'h0, 32'h1, 32'hFFFF, 32'h10000, 32'hFFFF_FFFF, 32'h8000_0000};
                for (int i = 0; i < 6; i++)
                begin
                        for (int j = 0; j < 6; j++)
                        begin
                                write_reg(4'd1, corners[i]);
                                write_reg(4'd2, corners[j]);
                                run_and_check(4'd3, 4'd1, 4'd2, 4'd0, 1'b0);
                        end
                end
                $display("test plain_multiply finished, %0d errors", fail_count - errors_before);
        endtask

        task automatic test_accumulate();
                mac_idx_t rd;
                mac_idx_t rm;
                mac_idx_t rs;
                mac_idx_t rn;
                int       errors_before;
                errors_before = fail_count;
                for (int k = 0; k < 20; k++)
                begin
                        rm = mac_idx_t'(next_random() >> 28);
                        rs = mac_idx_t'(next_random() >> 28);
                        rn = mac_idx_t'(next_random() >> 28);
                        rd = mac_idx_t'(next_random() >> 28);
                        if (k % 3 == 0)
                                rd = rm;                // Destination overwrites a source.
                        else if (k % 3 == 1)
                                rd = rn;
                        write_reg(rm, next_random());
                        write_reg(rs, next_random());
                        write_reg(rn, next_random());
                        run_and_check(rd, rm, rs, rn, 1'b1);
                end
                $display("test accumulate finished, %0d errors", fail_count - errors_before);
        endtask

        task automatic test_latency();
                mac_word_t expected;
                int        edges;
                logic      seen;
                int        errors_before;
                errors_before = fail_count;
                write_reg(4'd1, next_random());
                write_reg(4'd2, next_random());
                write_reg(4'd3, next_random());
                expected = expected_result(model_regs[1], model_regs[2], model_regs[3], 1'b1);
                issue_command(4'd4, 4'd1, 4'd2, 4'd3, 1'b1);
                edges = 0;
                seen  = 1'b0;
                while (!seen && edges < DONE_LIMIT)
                begin
                        compare_bit("busy during operation", o_busy, 1'b1);
                        if (edges == 2)
                                drive_command(4'd5, 4'd2, 4'd3, 4'd1, 1'b0);  // Must be ignored.
                        @(posedge i_clk);
                        edges++;
                        @(negedge i_clk);
                        i_cmd_valid = 1'b0;
                        seen = o_done;
                end
                compare_count("edges from command to done", edges, DONE_EDGES);
                compare_bit("busy while done", o_busy, 1'b1);
                @(posedge i_clk);
                @(negedge i_clk);
                compare_bit("done lasts one cycle", o_done, 1'b0);
                compare_bit("busy after writeback", o_busy, 1'b0);
                model_regs[4] = expected;
                check_all_regs();                       // Register 5 stays untouched.
                $display("test latency finished, %0d errors", fail_count - errors_before);
        endtask

        task automatic test_flush();
                mac_word_t got;
                int        errors_before;
                errors_before = fail_count;
                write_reg(4'd10, 32'h1234_5678);
                write_reg(4'd11, next_random());
                write_reg(4'd12, next_random());
                issue_command(4'd10, 4'd11, 4'd12, 4'd0, 1'b0);
                repeat (2)
                begin
                        @(posedge i_clk);
                        @(negedge i_clk);
                end
                i_flush = 1'b1;
                @(posedge i_clk);
                @(negedge i_clk);
                i_flush = 1'b0;
                compare_bit("busy after flush", o_busy, 1'b0);
                for (int i = 0; i < 8; i++)
                begin
                        compare_bit("done after flush", o_done, 1'b0);
                        @(posedge i_clk);
                        @(negedge i_clk);
                end
                read_reg(4'd10, got);
                compare_word("flushed destination", got, model_regs[10]);
                run_and_check(4'd10, 4'd11, 4'd12, 4'd0, 1'b0);
                $display("test flush finished, %0d errors", fail_count - errors_before);
        endtask

        //####################################################################
        // Main sequence and watchdog.
        //####################################################################

        initial
        begin
                i_clk            = 1'b0;
                i_reset          = 1'b1;
                i_reg_we         = 1'b0;
                i_reg_waddr      = '0;
                i_reg_wdata      = '0;
                i_reg_raddr      = '0;
                i_cmd_valid      = 1'b0;
                i_cmd_rd         = '0;
                i_cmd_rm         = '0;
                i_cmd_rs         = '0;
                i_cmd_rn         = '0;
                i_cmd_accumulate = 1'b0;
                i_flush          = 1'b0;
                hold_reset();

                test_reset_and_regs();
                test_plain_multiply();
                test_accumulate();
                test_latency();
                test_flush();

                $display("checks passed %0d, failed %0d", pass_count, fail_count);
                if (fail_count == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

        initial
        begin
                #(WATCHDOG_NS);
                $display("Run timed out after %0d ns before the tests finished", WATCHDOG_NS);
                $display("Test failed");
                $finish;
        end

endmodule
